//--- bench/prbs_testdata.txt
# op addr data expect, all hex; W writes, R compares, WAIT polls until (read & data) == expect
# INJ makes data rising edges on addr; R of 14 with data 1 checks nonzero and the checker lfsr
R    00  00000000  00000000
R    04  00000000  00000001
R    08  00000000  80200003
R    10  00000000  00000000
R    14  00000000  00000000
R    18  00000000  00000001
W    00  00000003  00000000
WAIT 14  00000040  00000040
W    00  00000002  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
R    14  00000001  00000000
W    00  00000001  00000000
WAIT 18  00000002  00000002
R    18  00000000  00001002
W    00  00000002  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
R    14  00000001  00000000
W    00  00000033  00000000
INJ  0C  00000003  00000000
W    00  00000002  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000003
R    14  00000001  00000000
W    00  00000037  00000000
WAIT 14  00000020  00000020
W    00  00000006  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
W    00  0000003B  00000000
WAIT 14  00000020  00000020
W    00  0000000A  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
W    00  0000003F  00000000
WAIT 14  00000020  00000020
W    00  0000000E  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
R    14  00000001  00000000
W    04  0000ACE1  00000000
W    08  80000057  00000000
W    00  00000001  00000000
WAIT 18  00000002  00000002
W    00  00000020  00000000
R    18  00000000  00000001
R    04  00000000  0000ACE1
W    00  00000010  00000000
R    10  00000000  00000000
R    14  00000000  00000000
W    00  00000003  00000000
WAIT 14  00000040  00000040
W    00  00000002  00000000
WAIT 18  00000001  00000001
R    10  00000000  00000000
R    14  00000001  00000000

//--- filelist.f
+incdir+verilog
verilog/prbs_pkg.sv
verilog/bit_fifo.sv
verilog/prbs_generator.sv
verilog/prbs_checker.sv
verilog/prbs_apb_regs.sv
verilog/prbs_loopback_top.sv
bench/prbs_loopback_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= prbs_loopback_tb
SEED      ?= 1
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/prbs_loopback_tb.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_loopback_tb;
    import prbs_pkg::*;

    localparam int POLL_LIMIT = 500;

    logic               clk;
    logic               rst;
    logic [`APB_AW-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_data_t          pwdata;
    apb_data_t          prdata;
    logic               pready;
    logic               pslverr;

    int          checks;
    int          errors;
    int          timeouts;
    integer      seed;
    // configuration as the testbench believes the DUT holds it
    prbs_state_t run_init;
    prbs_state_t next_init;
    prbs_state_t cur_eqn;
    inv_t        cur_inv;

    prbs_loopback_top UUT (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // all bus tasks start and end 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic apb_write(input logic [`APB_AW-1:0] addr, input apb_data_t data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        wait_cycles(1);
        penable = 1'b1;
        // mid access cycle, well clear of the edges
        #10;
        check_flag(pready, 1'b1, "pready");
        check_flag(pslverr, 1'b0, "pslverr");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr, output apb_data_t data);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        wait_cycles(1);
        penable = 1'b1;
        // mid access cycle, well clear of the edges
        #10;
        data = prdata;
        check_flag(pready, 1'b1, "pready");
        check_flag(pslverr, 1'b0, "pslverr");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic poll_register(input logic [`APB_AW-1:0] addr, input apb_data_t mask,
                                 input apb_data_t want);
        apb_data_t rd;
        int        polls;
        polls = 0;
        apb_read(addr, rd);
        while ((rd & mask) !== want && polls < POLL_LIMIT) begin
            polls++;
            apb_read(addr, rd);
        end
        if ((rd & mask) !== want) begin
            timeouts++;
            $display("timeout at %0t: register 0x%02h never reached 0x%08h under mask 0x%08h",
                     $time, addr, want, mask);
        end
    endtask

    // each edge is wider than 4 cycles in both phases
    task automatic inject_errors(input logic [`APB_AW-1:0] addr, input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            apb_write(addr, 32'h1);
            gap = 5 + ($unsigned($random(seed)) % 6);
            wait_cycles(gap);
            apb_write(addr, 32'h0);
            gap = 5 + ($unsigned($random(seed)) % 6);
            wait_cycles(gap);
        end
    endtask

    // fibonacci step, taps xored, feedback optionally inverted
    function automatic prbs_state_t model_state(input prbs_state_t start, input prbs_state_t taps,
                                                input inv_t iv, input count_t steps);
        prbs_state_t s;
        s = start;
        for (int i = 0; i < int'(steps); i++) begin
            s = {s[`PRBS_WIDTH-2:0], (^(s & taps)) ^ iv[0]};
        end
        return s;
    endfunction

    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_data(input apb_data_t got, input apb_data_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, want);
        end
    endtask

    task automatic check_count(input count_t got, input count_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_nonzero(input count_t got, input string what);
        checks++;
        if ($isunknown(got) || got == '0) begin
            errors++;
            $display("[FAIL] %0t: %s is %0d, expected nonzero", $time, what, got);
        end
    endtask

    task automatic check_state(input prbs_state_t got, input prbs_state_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s state 0x%08h, expected 0x%08h", $time, what, got, want);
        end
    endtask

    initial begin
        integer             fd;
        integer             code;
        string              line;
        logic [63:0]        op;
        logic [`APB_AW-1:0] addr;
        apb_data_t          data;
        apb_data_t          want;
        apb_data_t          rd;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        seed      = 32'h12e96d65;
        run_init  = 32'h0000_0001;
        next_init = 32'h0000_0001;
        cur_eqn   = 32'h8020_0003;
        cur_inv   = '0;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("bench/prbs_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bench/prbs_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0) begin
                    break;
                end
                if (line.len() < 4 || line.getc(0) == "#") begin
                    continue;
                end
                code = $sscanf(line, "%s %h %h %h", op, addr, data, want);
                if (code != 4) begin
                    continue;
                end
                if (op == "W") begin
                    apb_write(addr, data);
                    if (addr == `REG_INIT) begin
                        next_init = data;
                    end else if (addr == `REG_EQN) begin
                        cur_eqn = data;
                    end else if (addr == `REG_CTRL) begin
                        cur_inv = data[3:2];
                        if (data[5]) begin
                            run_init = next_init;
                        end
                    end
                end else if (op == "R") begin
                    apb_read(addr, rd);
                    if (addr == `REG_BITCNT && data != 0) begin
                        // count only known to be nonzero, checker lfsr must match it
                        check_nonzero(rd, "bit counter");
                        check_state(UUT.u_chk.state, model_state(run_init, cur_eqn, cur_inv, rd),
                                    "checker lfsr");
                    end else if (addr == `REG_ERRCNT || addr == `REG_BITCNT) begin
                        check_count(rd, want, $sformatf("counter 0x%02h", addr));
                    end else begin
                        check_data(rd, want, $sformatf("register 0x%02h", addr));
                    end
                end else if (op == "WAIT") begin
                    poll_register(addr, data, want);
                end else if (op == "INJ") begin
                    inject_errors(addr, int'(data));
                end else begin
                    errors++;
                    $display("unknown operation in test data: %s", line);
                end
            end
            $fclose(fd);
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/prbs_loopback_top.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_loopback_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [`APB_AW-1:0]  paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  prbs_pkg::apb_data_t pwdata,
    output prbs_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr
);
    import prbs_pkg::*;

    logic        gen_en;
    logic        chk_en;
    inv_t        inv;
    prbs_state_t init_val;
    prbs_state_t eqn;
    logic        inj_err;
    logic        restart;
    logic        clear;
    logic        cke;
    logic        tx_bit;
    logic        tx_valid;
    logic        rx_bit;
    logic        rx_pop;
    logic        fifo_full;
    logic        fifo_empty;
    level_t      fifo_level;
    count_t      err_count;
    count_t      bit_count;

    prbs_apb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .gen_en     (gen_en),
        .chk_en     (chk_en),
        .inv        (inv),
        .init_val   (init_val),
        .eqn        (eqn),
        .inj_err    (inj_err),
        .restart    (restart),
        .clear      (clear),
        .err_count  (err_count),
        .bit_count  (bit_count),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .fifo_level (fifo_level)
    );

    // producer stalls while the channel is full
    assign cke = gen_en & ~fifo_full;

    prbs_generator u_gen (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .cke       (cke),
        .init_val  (init_val),
        .eqn       (eqn),
        .inj_err   (inj_err),
        .inv       (inv),
        .out_bit   (tx_bit),
        .out_valid (tx_valid)
    );

    bit_fifo #(
        .payload_t (logic)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (restart),
        .push      (tx_valid),
        .push_data (tx_bit),
        .pop       (rx_pop),
        .pop_data  (rx_bit),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .level     (fifo_level)
    );

    prbs_checker u_chk (
        .clk        (clk),
        .rst        (rst),
        .restart    (restart),
        .clear      (clear),
        .chk_en     (chk_en),
        .init_val   (init_val),
        .eqn        (eqn),
        .inv        (inv),
        .fifo_empty (fifo_empty),
        .fifo_data  (rx_bit),
        .pop        (rx_pop),
        .err_count  (err_count),
        .bit_count  (bit_count)
    );

endmodule

//--- verilog/prbs_apb_regs.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`APB_AW-1:0]    paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  prbs_pkg::apb_data_t   pwdata,
    output prbs_pkg::apb_data_t   prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  gen_en,
    output logic                  chk_en,
    output prbs_pkg::inv_t        inv,
    output prbs_pkg::prbs_state_t init_val,
    output prbs_pkg::prbs_state_t eqn,
    output logic                  inj_err,
    output logic                  restart,
    output logic                  clear,
    input  prbs_pkg::count_t      err_count,
    input  prbs_pkg::count_t      bit_count,
    input  logic                  fifo_empty,
    input  logic                  fifo_full,
    input  prbs_pkg::level_t      fifo_level
);
    import prbs_pkg::*;

    logic      wr_en;
    apb_data_t rdata;

    // access phase of a write, no wait states
    assign wr_en = psel & penable & pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            gen_en   <= 1'b0;
            chk_en   <= 1'b0;
            inv      <= '0;
            init_val <= prbs_state_t'(32'h0000_0001);
            eqn      <= prbs_state_t'(32'h8020_0003);
            inj_err  <= 1'b0;
            restart  <= 1'b0;
            clear    <= 1'b0;
        end else begin
            // pulses last a single cycle
            restart <= 1'b0;
            clear   <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    `REG_CTRL: begin
                        gen_en  <= pwdata[0];
                        chk_en  <= pwdata[1];
                        inv     <= pwdata[3:2];
                        clear   <= pwdata[4];
                        restart <= pwdata[5];
                    end
                    `REG_INIT: init_val <= pwdata[`PRBS_WIDTH-1:0];
                    `REG_EQN:  eqn      <= pwdata[`PRBS_WIDTH-1:0];
                    `REG_INJ:  inj_err  <= pwdata[0];
                    default: ;
                endcase
            end
        end
    end

    // read mux, combinational from the registers
    always_comb begin
        rdata = '0;
        case (paddr)
            `REG_CTRL:   rdata[3:0] = {inv, chk_en, gen_en};
            `REG_INIT:   rdata[`PRBS_WIDTH-1:0] = init_val;
            `REG_EQN:    rdata[`PRBS_WIDTH-1:0] = eqn;
            `REG_INJ:    rdata[0] = inj_err;
            `REG_ERRCNT: rdata = err_count;
            `REG_BITCNT: rdata = bit_count;
            `REG_STATUS: begin
                rdata[0] = fifo_empty;
                rdata[1] = fifo_full;
                rdata[8 +: `FIFO_AW+1] = fifo_level;
            end
            default: rdata = '0;
        endcase
    end

    assign prdata  = rdata;
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // access phase only follows a setup phase of the same transfer
    assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> (psel && $past(psel)));

endmodule

//--- verilog/prbs_checker.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  restart,
    input  logic                  clear,
    input  logic                  chk_en,
    input  prbs_pkg::prbs_state_t init_val,
    input  prbs_pkg::prbs_state_t eqn,
    input  prbs_pkg::inv_t        inv,
    input  logic                  fifo_empty,
    input  logic                  fifo_data,
    output logic                  pop,
    output prbs_pkg::count_t      err_count,
    output prbs_pkg::count_t      bit_count
);
    import prbs_pkg::*;

    prbs_state_t state;
    logic        feedback;
    logic        expected;
    logic        mismatch;

    // same update rule as the generator
    assign feedback = (^(state & eqn)) ^ inv[0];
    assign expected = state[`PRBS_WIDTH-1] ^ inv[1];

    assign pop      = chk_en & ~fifo_empty;
    assign mismatch = fifo_data ^ expected;

    // one lfsr step per popped bit
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state <= init_val;
        end else if (pop) begin
            state <= {state[`PRBS_WIDTH-2:0], feedback};
        end
    end

    // counters stick at all ones
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            bit_count <= '0;
            err_count <= '0;
        end else if (pop) begin
            if (bit_count != '1) begin
                bit_count <= bit_count + 1'b1;
            end
            if (mismatch && err_count != '1) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // a popped head must hold a written bit
    assert property (@(posedge clk) disable iff (rst) pop |-> !$isunknown(fifo_data));

endmodule

//--- verilog/prbs_generator.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_generator (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  restart,
    input  logic                  cke,
    input  prbs_pkg::prbs_state_t init_val,
    input  prbs_pkg::prbs_state_t eqn,
    input  logic                  inj_err,
    input  prbs_pkg::inv_t        inv,
    output logic                  out_bit,
    output logic                  out_valid
);
    import prbs_pkg::*;

    prbs_state_t state;
    logic [3:0]  inj_hist;
    logic        inj_pulse;
    logic        feedback;
    logic        pending;

    // rising edge of inj_err, delayed by the history register
    assign inj_pulse = inj_hist[2] & ~inj_hist[3];

    // xor of the tapped bits
    assign feedback = (^(state & eqn)) ^ inv[0];

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            inj_hist <= '0;
        end else if (cke) begin
            inj_hist <= {inj_hist[2:0], inj_err};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state <= init_val;
        end else if (cke) begin
            state <= {state[`PRBS_WIDTH-2:0], feedback};
        end
    end

    // output bit only moves on enabled cycles
    always_ff @(posedge clk) begin
        if (cke) begin
            out_bit <= state[`PRBS_WIDTH-1] ^ inj_pulse ^ inv[1];
        end
    end

    // out_bit holds a bit not yet handed to the fifo
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            pending <= 1'b0;
        end else if (cke) begin
            pending <= 1'b1;
        end
    end

    // handed over as the next bit is produced, so full blocks the push
    assign out_valid = pending & cke;

    // a nonzero seed with plain feedback never reaches the lock-up state
    assert property (@(posedge clk) disable iff (rst || restart)
        (!inv[0] && init_val != '0) |-> (state != '0));

endmodule

//--- verilog/bit_fifo.sv
`timescale 1ns/1ps
`include "prbs_defines.svh"

module bit_fifo #(
    parameter type payload_t = logic
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  payload_t         push_data,
    input  logic             pop,
    output payload_t         pop_data,
    output logic             full,
    output logic             empty,
    output prbs_pkg::level_t level
);
    import prbs_pkg::*;

    payload_t             mem [`FIFO_DEPTH];
    logic [`FIFO_AW-1:0]  wr_ptr;
    logic [`FIFO_AW-1:0]  rd_ptr;
    level_t               count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // first word fall through
    assign pop_data = mem[rd_ptr];
    assign full     = (count == level_t'(`FIFO_DEPTH));
    assign empty    = (count == '0);
    assign level    = count;

    // producer must respect back-pressure
    assert property (@(posedge clk) disable iff (rst) !(push && full));

    // consumer must not read past the tail
    assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

//--- verilog/prbs_pkg.sv
`include "prbs_defines.svh"

package prbs_pkg;

    // lfsr state, also used for the seed and the tap mask
    typedef logic [`PRBS_WIDTH-1:0] prbs_state_t;

    // apb read and write data
    typedef logic [31:0] apb_data_t;

    // saturating bit and error counters
    typedef logic [31:0] count_t;

    // bit 0 inverts the feedback, bit 1 inverts the output
    typedef logic [1:0] inv_t;

    // fifo fill level, one bit wider than the pointers
    typedef logic [`FIFO_AW:0] level_t;

endpackage

//--- verilog/prbs_defines.svh
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// lfsr length
`define PRBS_WIDTH 32

// channel buffer
`define FIFO_DEPTH 16
`define FIFO_AW    4

// apb address width
`define APB_AW 8

// register map
`define REG_CTRL   8'h00
`define REG_INIT   8'h04
`define REG_EQN    8'h08
`define REG_INJ    8'h0C
`define REG_ERRCNT 8'h10
`define REG_BITCNT 8'h14
`define REG_STATUS 8'h18

`endif
